// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // Character width for 8N1 framing
  localparam int DATA_BITS = 8;

  // Receiver FSM of the oversampling receiver
  typedef enum logic [1:0] {
    RX_IDLE      = 2'd0,  // Waiting for a start edge on an idle line
    RX_START     = 2'd1,  // Start edge seen and baud generator released
    RX_RECEIVING = 2'd2,  // Counting half-bit ticks and sampling at mid-bit
    RX_FINISH    = 2'd3   // Frame done and output register loaded
  } rx_state_e;

  // Transmitter FSM with one state per part of the frame
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // Line high and ready for tx_start
    TX_START = 2'd1,  // Driving the start bit
    TX_DATA  = 2'd2,  // Driving data bits LSB first
    TX_STOP  = 2'd3   // Driving the stop bit
  } tx_state_e;

  // One received character
  // frame_err is set when the stop bit was sampled low
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 frame_err;
  } rx_char_t;

  // One character to send
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
  } tx_char_t;

endpackage

// ==== rtl/baud_gen.sv ====
module baud_gen #(
  parameter int DIVISOR = 16  // Clocks between ticks
) (
  input  logic clk,
  input  logic rstn,
  input  logic restart,  // Holds the divider cleared
  output logic tick      // One-cycle pulse every DIVISOR clocks
);

  // Counter width, at least one bit even for DIVISOR of 1
  localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVISOR - 1);

  logic [CNT_W-1:0] cnt;

  // Runs 0 .. DIVISOR-1 and wraps
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (restart) begin
      cnt <= '0;  // Bit timing restarts from here
    end else if (cnt == CNT_LAST) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Tick on the last count of each period
  // First tick is DIVISOR clocks after restart drops
  assign tick = !restart && (cnt == CNT_LAST);

endmodule

// ==== rtl/uart_rx.sv ====
module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 104  // Must be even
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     rx,        // Serial line, idle high
  output rx_char_t rx_char,   // Held until the next frame ends
  output logic     rx_valid   // One-cycle strobe
);

  // Half-bit tick counts, odd counts land at mid-bit
  // 1 is the start bit, 3..17 the data bits, 19 the stop bit
  localparam logic [4:0] FIRST_CNT     = 5'd1;
  localparam logic [4:0] LAST_DATA_CNT = 5'(2 * DATA_BITS + 1);
  localparam logic [4:0] STOP_CNT      = 5'(2 * DATA_BITS + 3);

  rx_state_e state;

  logic rx_meta;   // First synchroniser stage
  logic rx_sync;   // Line in the clk domain
  logic rx_last;   // Previous rx_sync, for edge detection
  logic start_edge;

  logic tick;       // Half-bit tick from baud_gen
  logic restart;    // FSM outputs
  logic cnt_en;
  logic shift_en;
  logic load;

  logic [4:0] tick_cnt;
  logic [4:0] tick_next;
  logic       glitch;   // Line back high at the start-bit middle

  logic [DATA_BITS-1:0] shifter;
  logic                 stop_bit;

  // 2-flop synchroniser plus one flop for the falling edge
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign start_edge = rx_last && !rx_sync;  // High to low

  // Half-bit divider, released when the start edge is seen
  baud_gen #(
    .DIVISOR(CLKS_PER_BIT / 2)
  ) baud_i (
    .clk    (clk),
    .rstn   (rstn),
    .restart(restart),
    .tick   (tick)
  );

  // Moore outputs of the FSM
  always_comb begin
    restart  = 1'b1;
    cnt_en   = 1'b0;
    shift_en = 1'b0;
    load     = 1'b0;
    case (state)
      RX_START, RX_RECEIVING: begin
        restart  = 1'b0;  // Run the baud generator
        cnt_en   = 1'b1;
        shift_en = 1'b1;
      end
      RX_FINISH: load = 1'b1;  // Frame complete
      default: ;
    endcase
  end

  assign tick_next = tick_cnt + 5'd1;
  assign glitch    = tick && (tick_next == FIRST_CNT) && rx_sync;

  // Tick counter, cleared whenever the FSM is not receiving
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tick_cnt <= '0;
    end else if (!cnt_en) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= tick_next;
    end
  end

  // Shift register enabled by tick, takes the line on odd counts
  // Start bit goes in first and is pushed out by the 8th data bit
  always_ff @(posedge clk) begin
    if (!rstn) begin
      shifter <= '1;
    end else if (shift_en && tick && tick_next[0] && (tick_next <= LAST_DATA_CNT)) begin
      shifter <= {rx_sync, shifter[DATA_BITS-1:1]};
    end
  end

  // Stop-bit sample
  always_ff @(posedge clk) begin
    if (shift_en && tick && (tick_next == STOP_CNT)) begin
      stop_bit <= rx_sync;
    end
  end

  // State transitions
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= RX_IDLE;
    end else begin
      case (state)
        RX_IDLE: begin
          if (start_edge) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          state <= glitch ? RX_IDLE : RX_RECEIVING;
        end
        RX_RECEIVING: begin
          if (glitch) begin
            state <= RX_IDLE;  // Noise, no strobe
          end else if (tick_cnt == STOP_CNT) begin
            state <= RX_FINISH;
          end
        end
        RX_FINISH: state <= RX_IDLE;  // One cycle only
        default:   state <= RX_IDLE;
      endcase
    end
  end

  // Output register and strobe update on the same edge
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_char  <= '{data: '1, frame_err: 1'b0};
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= load;
      if (load) begin
        rx_char.data      <= shifter;
        rx_char.frame_err <= !stop_bit;  // Stop bit must be high
      end
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 104
) (
  input  logic     clk,
  input  logic     rstn,
  input  tx_char_t tx_char,
  input  logic     tx_start,  // One-cycle request, dropped while busy
  output logic     tx,        // Serial line, idle high
  output logic     tx_busy
);

  localparam int BIT_CNT_W = $clog2(DATA_BITS);
  localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(DATA_BITS - 1);

  tx_state_e state;

  logic                 restart;
  logic                 tick;      // One per bit period
  logic [DATA_BITS-1:0] tx_shift;  // Remaining data bits
  logic [BIT_CNT_W-1:0] bit_cnt;   // Data bits already sent

  // Generator is held cleared while idle, so the first bit
  // lasts a full period from the cycle after tx_start
  assign restart = (state == TX_IDLE);
  assign tx_busy = (state != TX_IDLE);  // Rises with the start bit

  baud_gen #(
    .DIVISOR(CLKS_PER_BIT)
  ) baud_i (
    .clk    (clk),
    .rstn   (rstn),
    .restart(restart),
    .tick   (tick)
  );

  // Data latch and shifter
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx_start) begin
      tx_shift <= tx_char.data;  // Captured on accept
    end else if (tick && state != TX_IDLE && state != TX_STOP) begin
      tx_shift <= tx_shift >> 1;  // Next bit into position 0
    end
  end

  // FSM, line driver and bit counter
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= TX_IDLE;
      tx      <= 1'b1;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_start) begin
            state   <= TX_START;
            tx      <= 1'b0;  // Start bit
            bit_cnt <= '0;
          end
        end
        TX_START: begin
          if (tick) begin
            state <= TX_DATA;
            tx    <= tx_shift[0];  // LSB first
          end
        end
        TX_DATA: begin
          if (tick) begin
            if (bit_cnt == LAST_BIT) begin
              state <= TX_STOP;
              tx    <= 1'b1;  // Stop bit
            end else begin
              tx      <= tx_shift[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        TX_STOP: begin
          if (tick) begin
            state <= TX_IDLE;  // Line stays high
          end
        end
        default: begin
          state <= TX_IDLE;
          tx    <= 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== rtl/uart_core.sv ====
module uart_core
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 104  // Even, clocks per serial bit
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx,          // Serial in, idle high
  output logic       tx,          // Serial out, idle high
  output rx_char_t   rx_char,     // Last received character
  output logic       rx_valid,    // Strobe, one cycle per frame
  input  tx_char_t   tx_char,     // Character to send
  input  logic       tx_start,    // Strobe, taken only when not busy
  output logic       tx_busy,
  output logic [7:0] char_count   // Good characters received, wraps
);

  // Receive half
  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) rx_i (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rx_char (rx_char),
    .rx_valid(rx_valid)
  );

  // Transmit half
  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) tx_i (
    .clk     (clk),
    .rstn    (rstn),
    .tx_char (tx_char),
    .tx_start(tx_start),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  // Good-character counter
  // Frames with a low stop bit are not counted
  always_ff @(posedge clk) begin
    if (!rstn) begin
      char_count <= '0;
    end else if (rx_valid && !rx_char.frame_err) begin
      char_count <= char_count + 8'd1;  // Wraps at 255
    end
  end

endmodule

// ==== sim/uart_tb.sv ====
module uart_tb
  import uart_pkg::*;
();

  localparam int CLKS_PER_BIT   = 16;
  localparam int NUM_FRAMES     = 16;  // 4 rx, 2 framing, 2 tx, 8 loopback
  localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * 12 * CLKS_PER_BIT) + 200;

  logic       clk = 1'b0;
  logic       rstn;
  logic       rx_drive;   // Line driven by the testbench
  logic       loopback;   // Feeds tx back into rx
  logic       rx_line;
  logic       tx;
  rx_char_t   rx_char;
  logic       rx_valid;
  tx_char_t   tx_char;
  logic       tx_start;
  logic       tx_busy;
  logic [7:0] char_count;

  rx_char_t   rx_q[$];          // Characters seen with rx_valid
  logic [7:0] exp_count = '0;   // Model of the good-character counter
  logic [31:0] lcg_state = 32'h3f5b;
  int err_cnt   = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  int cycle_cnt = 0;

  always #2 clk = ~clk;  // Period 4

  assign rx_line = loopback ? tx : rx_drive;

  uart_core #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) dut_i (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx_line),
    .tx        (tx),
    .rx_char   (rx_char),
    .rx_valid  (rx_valid),
    .tx_char   (tx_char),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .char_count(char_count)
  );

  // Strobe capture on the falling edge
  always @(negedge clk) begin
    if (rstn && rx_valid) rx_q.push_back(rx_char);
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Run hung, still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Park inputs 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start) begin
      pass_cnt++;
      $display("[PASS] %s", name);
    end else begin
      fail_cnt++;
      $display("[FAIL] %s, %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // Bit-bang one 8N1 frame on rx LSB first
  task automatic send_frame(input logic [7:0] data, input logic bad_stop);
    rx_drive = 1'b0;  // Start bit
    repeat (CLKS_PER_BIT) next_cycle();
    for (int i = 0; i < 8; i++) begin
      rx_drive = data[i];
      repeat (CLKS_PER_BIT) next_cycle();
    end
    rx_drive = !bad_stop;  // Stop bit held low to force a framing error
    repeat (CLKS_PER_BIT) next_cycle();
    rx_drive = 1'b1;
  endtask

  task automatic idle_bits(input int n);
    rx_drive = 1'b1;
    repeat (n * CLKS_PER_BIT) next_cycle();
  endtask

  // Wait for a captured character and check it
  task automatic expect_char(input logic [7:0] data, input logic frame_err,
                             input int limit);
    rx_state_e rx_st;
    rx_char_t  got;
    int        n;
    n = 0;
    while (rx_q.size() == 0 && n < limit) begin
      next_cycle();
      n++;
    end
    rx_st = dut_i.rx_i.state;
    assert (rx_q.size() != 0) else begin
      $display("Missing rx_valid strobe at time %0t, receiver state %s",
               $time, rx_st.name());
      err_cnt++;
    end
    if (rx_q.size() != 0) begin
      got = rx_q.pop_front();
      check_value("rx_char.data", data, got.data);
      check_value("rx_char.frame_err", frame_err, got.frame_err);
      check_value("extra rx_valid strobes", 0, rx_q.size());
      if (!frame_err) exp_count = exp_count + 8'd1;  // Only good frames count
    end
    next_cycle();  // Counter updates one cycle after the strobe
    check_value("char_count", exp_count, char_count);
  endtask

  // Pulse tx_start and sample tx at each mid-bit until busy drops
  task automatic send_and_check_tx(input logic [7:0] data, input logic inject,
                                   input logic [7:0] other);
    int   n;
    int   idx;
    int   busy_len;
    logic exp_bit;
    logic done;
    n        = 0;
    busy_len = 0;
    done     = 1'b0;
    tx_char.data = data;
    tx_start     = 1'b1;
    next_cycle();
    tx_start = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (tx_busy) begin
        busy_len++;
        if (n % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
          idx     = n / CLKS_PER_BIT;
          exp_bit = (idx == 0) ? 1'b0 : (idx >= 9) ? 1'b1 : data[idx-1];
          check_value($sformatf("tx bit %0d", idx), exp_bit, tx);
        end
      end else begin
        done = 1'b1;
      end
      next_cycle();
      tx_start = inject && (n == 4 * CLKS_PER_BIT + 3);  // Mid-frame request
      if (tx_start) tx_char.data = other;
      n++;
      if (!done && n > 11 * CLKS_PER_BIT) begin
        $display("tx_busy never fell after tx_start, time %0t", $time);
        err_cnt++;
        done = 1'b1;
      end
    end
    tx_start = 1'b0;
    check_value("tx_busy length", 10 * CLKS_PER_BIT, busy_len);
    check_value("tx idle level", 1'b1, tx);
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    check_value("tx", 1'b1, tx);
    check_value("tx_busy", 1'b0, tx_busy);
    check_value("rx_valid", 1'b0, rx_valid);
    check_value("char_count", 8'h00, char_count);
    check_value("rx_char.frame_err", 1'b0, rx_char.frame_err);
    check_value("rx_char.data", 8'hff, rx_char.data);
    end_test("reset state", e0);
  endtask

  task automatic test_receive();
    logic [7:0] bytes [4];
    int         e0;
    e0 = err_cnt;
    bytes = '{8'h55, 8'h00, 8'hff, 8'ha3};
    rx_q.delete();
    foreach (bytes[i]) begin
      send_frame(bytes[i], 1'b0);
      expect_char(bytes[i], 1'b0, 2 * CLKS_PER_BIT);  // 12 bit times from start
    end
    end_test("receive", e0);
  endtask

  task automatic test_frame_error();
    int e0;
    e0 = err_cnt;
    rx_q.delete();
    send_frame(8'h3c, 1'b1);
    expect_char(8'h3c, 1'b1, 2 * CLKS_PER_BIT);
    idle_bits(1);
    send_frame(8'h96, 1'b0);  // Receiver recovers
    expect_char(8'h96, 1'b0, 2 * CLKS_PER_BIT);
    end_test("framing error", e0);
  endtask

  task automatic test_transmit();
    int e0;
    e0 = err_cnt;
    send_and_check_tx(8'hc5, 1'b0, 8'h00);
    end_test("transmit", e0);
  endtask

  task automatic test_back_pressure();
    int e0;
    e0 = err_cnt;
    idle_bits(1);
    send_and_check_tx(8'hc5, 1'b1, 8'h3a);
    repeat (4) next_cycle();
    check_value("tx_busy after dropped start", 1'b0, tx_busy);
    end_test("back-pressure", e0);
  endtask

  task automatic test_loopback();
    logic [7:0] b;
    logic [7:0] count_before;
    logic [7:0] count_after;
    int         e0;
    int         n;
    e0 = err_cnt;
    count_before = exp_count;
    rx_q.delete();
    loopback = 1'b1;
    repeat (8) begin
      lcg_state = lcg(lcg_state);
      b = lcg_state[30:23];
      tx_char.data = b;
      tx_start     = 1'b1;
      next_cycle();
      tx_start = 1'b0;
      expect_char(b, 1'b0, 12 * CLKS_PER_BIT);
      n = 0;
      while (tx_busy && n < 2 * CLKS_PER_BIT) begin  // Let the stop bit finish
        next_cycle();
        n++;
      end
      check_value("tx_busy before next frame", 1'b0, tx_busy);
      repeat (CLKS_PER_BIT) next_cycle();  // One idle bit
    end
    loopback = 1'b0;
    count_after = count_before + 8'd8;  // 8-bit counter wraps
    check_value("char_count gain", count_after, char_count);
    end_test("loopback", e0);
  endtask

  initial begin
    rstn     = 1'b0;
    rx_drive = 1'b1;
    loopback = 1'b0;
    tx_start = 1'b0;
    tx_char  = '0;
    repeat (5) next_cycle();  // Reset held 5 cycles
    rstn = 1'b1;
    next_cycle();
    test_reset();
    test_receive();
    test_frame_error();
    test_transmit();
    test_back_pressure();
    test_loopback();
    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/uart_pkg.sv
rtl/baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_core.sv
sim/uart_tb.sv
